//--- design/dcache_pkg.sv
package dcache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Cache geometry
  //////////////////////////////////////////////////////////////////////
  localparam int WAYS       = 4;
  localparam int SETS       = 16;
  localparam int LINE_WORDS = 16;
  localparam int TAG_W      = 22;
  localparam int INDEX_W    = 4;
  localparam int WORD_W     = 4;

  // Controller state codes
  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_LOOKUP = 3'd1;
  localparam logic [2:0] ST_WB     = 3'd2;
  localparam logic [2:0] ST_FILL   = 3'd3;
  localparam logic [2:0] ST_RESP   = 3'd4;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  byte_en_t;  // bit n covers byte n
  typedef logic [1:0]  way_t;
  typedef logic [1:0]  age_t;

  // CPU address, flat or split into its fields
  typedef union packed {
    word_t flat;
    struct packed {
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] index;
      logic [WORD_W-1:0]  word;
      logic [1:0]         byte_off;
    } f;
  } dcache_addr_u;

endpackage

//--- design/way_lookup.sv
`timescale 1ns/1ps

module way_lookup import dcache_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  dcache_addr_u     lookup_addr,
  input  logic             touch,
  input  way_t             touch_way,
  input  logic             fill,
  input  logic             set_dirty,
  output logic             hit,
  output way_t             hit_way,
  output way_t             victim_way,
  output logic             victim_dirty,
  output logic [TAG_W-1:0] victim_tag
);

  logic [TAG_W-1:0]   tag_mem [WAYS][SETS];
  logic               valid   [WAYS][SETS];
  logic               dirty   [WAYS][SETS];
  age_t               age     [WAYS][SETS];
  logic [INDEX_W-1:0] idx;
  logic [WAYS-1:0]    match;
  logic               found;

  assign idx          = lookup_addr.f.index;
  assign hit          = |match;
  assign victim_dirty = dirty[victim_way][idx];
  assign victim_tag   = tag_mem[victim_way][idx];

  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++)
      match[w] = valid[w][idx] && (tag_mem[w][idx] == lookup_addr.f.tag);
    for (int w = WAYS - 1; w >= 0; w--)
      if (match[w])
        hit_way = way_t'(w);
  end

  // Invalid way first, else oldest, lowest number on a tie
  always_comb
  begin
    victim_way = '0;
    found      = 1'b0;
    for (int w = 0; w < WAYS; w++)
      if (!found && !valid[w][idx])
      begin
        victim_way = way_t'(w);
        found      = 1'b1;
      end
    if (!found)
      for (int w = 1; w < WAYS; w++)
        if (age[w][idx] > age[victim_way][idx])
          victim_way = way_t'(w);
  end

  always_ff @(posedge clk)
    if (fill)
      tag_mem[victim_way][idx] <= lookup_addr.f.tag;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < WAYS; w++)
        for (int s = 0; s < SETS; s++)
        begin
          valid[w][s] <= 1'b0;
          dirty[w][s] <= 1'b0;
          age[w][s]   <= '0;
        end
    end
    else
    begin
      if (fill)
      begin
        valid[victim_way][idx] <= 1'b1;
        dirty[victim_way][idx] <= 1'b0;
      end
      if (set_dirty)
        dirty[touch_way][idx] <= 1'b1;
      if (touch)
      begin
        for (int w = 0; w < WAYS; w++)
          if (age[w][idx] <= age[touch_way][idx])
            age[w][idx] <= age[w][idx] + 1'b1;
        age[touch_way][idx] <= '0;  // most recent
      end
    end
  end

  a_one_match: assert property (@(posedge clk) disable iff (rst) $onehot0(match));

endmodule

//--- design/line_store.sv
`timescale 1ns/1ps

module line_store import dcache_pkg::*; (
  input  logic               clk,
  input  way_t               way,
  input  logic [INDEX_W-1:0] index,
  input  logic [WORD_W-1:0]  word,
  input  byte_en_t           cpu_we,
  input  word_t              cpu_wdata,
  input  logic               fill_we,
  input  word_t              fill_wdata,
  output word_t              rd_data
);

  //////////////////////////////////////////////////////////////////////
  // Data array, one word per way, set and line word
  //////////////////////////////////////////////////////////////////////
  word_t mem [WAYS][SETS][LINE_WORDS];

  assign rd_data = mem[way][index][word];  // async read

  always_ff @(posedge clk)
  begin
    if (fill_we)
    begin
      mem[way][index][word] <= fill_wdata;
    end
    else
    begin
      // CPU store in byte lanes
      for (int b = 0; b < 4; b++)
        if (cpu_we[b])
          mem[way][index][word][b*8 +: 8] <= cpu_wdata[b*8 +: 8];
    end
  end

endmodule

//--- design/line_transfer.sv
`timescale 1ns/1ps

module line_transfer import dcache_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              start_wb,
  input  logic              start_fill,
  input  word_t             wb_base,
  input  word_t             fill_base,
  input  logic              rdata_ok,
  input  word_t             sdata,
  input  logic              wdata_ok,
  output logic              sen,
  output word_t             raddr,
  output logic              wen,
  output word_t             waddr,
  output logic [WORD_W-1:0] xfer_word,
  output logic              fill_we,
  output word_t             fill_wdata,
  output logic              xfer_done
);

  logic [WORD_W-1:0] rd_cnt, wr_cnt;
  logic              rd_last, wr_last;

  assign rd_last    = sen && rdata_ok && (&rd_cnt);
  assign wr_last    = wen && wdata_ok && (&wr_cnt);
  assign xfer_word  = wen ? wr_cnt : rd_cnt;
  assign fill_we    = sen && rdata_ok;
  assign fill_wdata = sdata;

  //////////////////////////////////////////////////////////////////////
  // Refill and write-back counters
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sen       <= 1'b0;
      wen       <= 1'b0;
      rd_cnt    <= '0;
      wr_cnt    <= '0;
      xfer_done <= 1'b0;
    end
    else
    begin
      xfer_done <= rd_last || wr_last;
      if (start_fill)
      begin
        sen    <= 1'b1;
        rd_cnt <= '0;
      end
      else if (sen && rdata_ok)
      begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_last)
          sen <= 1'b0;  // falls after word 15
      end
      if (start_wb)
      begin
        wen    <= 1'b1;
        wr_cnt <= '0;
      end
      else if (wen && wdata_ok)
      begin
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_last)
          wen <= 1'b0;
      end
    end
  end

  // Line bases, held for the whole transfer
  always_ff @(posedge clk)
  begin
    if (start_fill)
      raddr <= fill_base;
    if (start_wb)
      waddr <= wb_base;
  end

  a_sen_wen: assert property (@(posedge clk) disable iff (rst) !(sen && wen));

endmodule

//--- design/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import dcache_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  logic              wreq,
  input  byte_en_t          wbyte,
  input  word_t             addr,
  input  word_t             din,
  input  logic              hit,
  input  way_t              hit_way,
  input  way_t              victim_way,
  input  logic              victim_dirty,
  input  logic [TAG_W-1:0]  victim_tag,
  input  word_t             rd_data,
  input  logic [WORD_W-1:0] xfer_word,
  input  logic              xfer_done,
  output word_t             ins,
  output logic              ok,
  output logic              miss,
  output dcache_addr_u      lookup_addr,
  output logic              touch,
  output way_t              touch_way,
  output logic              fill,
  output logic              set_dirty,
  output way_t              store_way,
  output logic [WORD_W-1:0] store_word,
  output byte_en_t          cpu_we,
  output word_t             cpu_wdata,
  output logic              start_wb,
  output logic              start_fill,
  output word_t             wb_base,
  output word_t             fill_base
);

  logic [2:0] state;
  logic       wreq_r, accept, in_lookup, busy;
  byte_en_t   wbyte_r;
  word_t      din_r, merged;

  assign accept    = req && ((state == ST_IDLE) || (state == ST_RESP));
  assign in_lookup = (state == ST_LOOKUP);
  assign busy      = in_lookup || (state == ST_WB) || (state == ST_FILL);
  assign ok        = (state == ST_RESP);

  assign touch      = in_lookup && hit;
  assign touch_way  = hit_way;
  assign set_dirty  = touch && wreq_r;
  assign cpu_we     = set_dirty ? wbyte_r : '0;
  assign cpu_wdata  = din_r;
  assign start_wb   = in_lookup && !hit && victim_dirty;
  assign start_fill = (in_lookup && !hit && !victim_dirty) || ((state == ST_WB) && xfer_done);
  assign fill       = (state == ST_FILL) && xfer_done;  // tag, valid, clean
  assign store_way  = in_lookup ? hit_way : victim_way;
  assign store_word = in_lookup ? lookup_addr.f.word : xfer_word;
  assign wb_base    = {victim_tag, lookup_addr.f.index, {(WORD_W + 2){1'b0}}};
  assign fill_base  = {lookup_addr.flat[31:WORD_W+2], {(WORD_W + 2){1'b0}}};

  // Byte merge for the write hit
  always_comb
  begin
    for (int b = 0; b < 4; b++)
      merged[b*8 +: 8] = (wreq_r && wbyte_r[b]) ? din_r[b*8 +: 8] : rd_data[b*8 +: 8];
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state       <= ST_IDLE;
      miss        <= 1'b0;
      wreq_r      <= 1'b0;
      lookup_addr <= '0;
    end
    else
    begin
      if (accept)
      begin
        lookup_addr.flat <= addr;
        wreq_r           <= wreq;
      end
      if (in_lookup)
        miss <= !hit;  // stays up through write-back and refill
      case (state)
        ST_IDLE, ST_RESP: state <= accept ? ST_LOOKUP : ST_IDLE;
        ST_LOOKUP:        state <= hit ? ST_RESP : (victim_dirty ? ST_WB : ST_FILL);
        ST_WB:            state <= xfer_done ? ST_FILL : ST_WB;
        ST_FILL:          state <= xfer_done ? ST_LOOKUP : ST_FILL;
        default:          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      wbyte_r <= wbyte;
      din_r   <= din;
    end
    if (touch)
      ins <= merged;
  end

  a_no_req_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !req);
  // Refilled line found by the repeated lookup
  a_fill_hit: assert property (@(posedge clk) disable iff (rst) fill |=> hit);

endmodule

//--- design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  // CPU side
  input  logic     req,
  input  logic     wreq,
  input  byte_en_t wbyte,
  input  word_t    addr,
  input  word_t    din,
  output word_t    ins,
  output logic     ok,
  output logic     miss,
  // Memory side
  output logic     sen,
  output word_t    raddr,
  input  word_t    sdata,
  input  logic     rdata_ok,
  output logic     wen,
  output word_t    waddr,
  output word_t    wdata,
  input  logic     wdata_ok
);

  dcache_addr_u      lookup_addr;
  logic              hit, victim_dirty;
  way_t              hit_way, victim_way, touch_way, store_way;
  logic [TAG_W-1:0]  victim_tag;
  logic              touch, fill, set_dirty;
  logic [WORD_W-1:0] store_word, xfer_word;
  byte_en_t          cpu_we;
  word_t             cpu_wdata, rd_data, wb_base, fill_base, fill_wdata;
  logic              start_wb, start_fill, xfer_done, fill_we;

  assign wdata = rd_data;  // write-back data straight from the array

  cache_ctrl ctrl_i (
    .clk, .rst, .req, .wreq, .wbyte, .addr, .din,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
    .rd_data, .xfer_word, .xfer_done,
    .ins, .ok, .miss, .lookup_addr, .touch, .touch_way, .fill, .set_dirty,
    .store_way, .store_word, .cpu_we, .cpu_wdata,
    .start_wb, .start_fill, .wb_base, .fill_base
  );

  way_lookup lookup_i (
    .clk, .rst, .lookup_addr, .touch, .touch_way, .fill, .set_dirty,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
  );

  line_store store_i (
    .clk, .way(store_way), .index(lookup_addr.f.index), .word(store_word),
    .cpu_we, .cpu_wdata, .fill_we, .fill_wdata, .rd_data
  );

  line_transfer xfer_i (
    .clk, .rst, .start_wb, .start_fill, .wb_base, .fill_base,
    .rdata_ok, .sdata, .wdata_ok,
    .sen, .raddr, .wen, .waddr, .xfer_word, .fill_we, .fill_wdata, .xfer_done
  );

endmodule

//--- testbench/mem_model.sv
`timescale 1ns/1ps

module mem_model import dcache_pkg::*; (
  input  logic  clk,
  input  logic  sen,
  input  word_t raddr,
  output word_t sdata,
  output logic  rdata_ok,
  input  logic  wen,
  input  word_t waddr,
  input  word_t wdata,
  output logic  wdata_ok
);

  word_t mem [logic [29:0]];  // only words written back are stored
  int    cnt;
  int    gap;

  function automatic word_t read_word(input logic [29:0] a);
    if (mem.exists(a))
      return mem[a];
    else
      return {2'b00, a} ^ 32'h5a5a0000;  // preset pattern
  endfunction

  // One process, so the seed covers every gap drawn below
  initial
  begin
    sdata    = '0;
    rdata_ok = 1'b0;
    wdata_ok = 1'b0;
    cnt      = 0;
    gap      = int'($urandom(32'hb67b) % 4);
    forever
    begin
      @(posedge clk);
      #1;
      rdata_ok = 1'b0;
      wdata_ok = 1'b0;
      if (!sen && !wen)
        cnt = 0;  // between transfers
      else if (gap > 0)
        gap--;
      else
      begin
        if (sen)
        begin
          sdata    = read_word(raddr[31:2] + 30'(cnt));
          rdata_ok = 1'b1;
        end
        else
        begin
          mem[waddr[31:2] + 30'(cnt)] = wdata;
          wdata_ok = 1'b1;
        end
        cnt++;
        gap = int'($urandom % 4);
      end
    end
  end

endmodule

//--- testbench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

  localparam string TEST_FILE       = "testbench/dcache_tests.txt";
  localparam int    RESET_CYCLES    = 10;
  localparam int    CYCLES_PER_TEST = 200;
  localparam int    HIT_LATENCY     = 2;  // req edge to ok

  logic     clk, rst, req, wreq;
  byte_en_t wbyte;
  word_t    addr, din, ins;
  logic     ok, miss, sen, wen, rdata_ok, wdata_ok;
  word_t    raddr, sdata, waddr, wdata;

  word_t kind_q[$], addr_q[$], data_q[$], mask_q[$], expect_q[$], miss_q[$];
  int    errors;
  int    n_tests;
  bit    loaded;

  dcache_top dut_i (
    .clk, .rst, .req, .wreq, .wbyte, .addr, .din, .ins, .ok, .miss,
    .sen, .raddr, .sdata, .rdata_ok, .wen, .waddr, .wdata, .wdata_ok
  );

  mem_model mem_i (
    .clk, .sen, .raddr, .sdata, .rdata_ok, .wen, .waddr, .wdata, .wdata_ok
  );

  initial
    clk = 1'b0;

  always
    #5 clk = ~clk;

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic load_tests();
    int    fd;
    string line;
    word_t k, a, d, m, e, x;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0)
    begin
      $display("Could not open the test file %s", TEST_FILE);
      errors++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
        if (line.len() > 1 && line[0] != "#" &&
            $sscanf(line, "%h %h %h %h %h %h", k, a, d, m, e, x) == 6)
        begin
          kind_q.push_back(k);
          addr_q.push_back(a);
          data_q.push_back(d);
          mask_q.push_back(m);
          expect_q.push_back(e);
          miss_q.push_back(x);
        end
      $fclose(fd);
      if (kind_q.size() == 0)
      begin
        $display("The test file %s holds no operations", TEST_FILE);
        errors++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One CPU access, then the checks once ok is seen
  //////////////////////////////////////////////////////////////////////
  task automatic run_op(input int i);
    int           cycles;
    int           wb_words;
    logic         miss_seen;
    word_t        fill_addr;
    dcache_addr_u req_a, wb_a;
    req_a.flat = addr_q[i];
    @(posedge clk);
    #1;
    req   = 1'b1;
    wreq  = (kind_q[i] == 32'd1);
    wbyte = mask_q[i][3:0];
    addr  = req_a.flat;
    din   = data_q[i];
    @(posedge clk);  // req sampled here
    #1;
    req       = 1'b0;
    wreq      = 1'b0;
    wbyte     = '0;
    cycles    = 0;
    wb_words  = 0;
    miss_seen = 1'b0;
    fill_addr = 'x;
    while (!ok)
    begin
      @(negedge clk);
      cycles++;
      miss_seen = miss_seen | miss;
      if (wen && wdata_ok)
        wb_words++;
      if (sen)
        fill_addr = raddr;
    end
    check_value("ins", ins, expect_q[i]);
    check_value("miss", word_t'(miss_seen), miss_q[i]);
    check_value("sen", word_t'(sen), '0);  // refill must be over
    if (miss_q[i] == 32'd0)
      check_value("ok latency", word_t'(cycles), word_t'(HIT_LATENCY));
    else
      check_value("raddr", fill_addr, {req_a.f.tag, req_a.f.index, 6'b0});
    check_value("wdata_ok count", word_t'(wb_words),
                (kind_q[i] == 32'd2) ? word_t'(LINE_WORDS) : '0);
    if (kind_q[i] == 32'd2)
    begin
      wb_a.flat = waddr;
      check_value("waddr index", word_t'(wb_a.f.index), word_t'(req_a.f.index));
    end
  endtask

  initial
  begin
    rst    = 1'b1;
    req    = 1'b0;
    wreq   = 1'b0;
    wbyte  = '0;
    addr   = '0;
    din    = '0;
    errors = 0;
    load_tests();
    n_tests = kind_q.size();
    loaded  = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < n_tests; i++)
      run_op(i);
    repeat (2) @(posedge clk);
    $display("%0d operations run, %0d errors", n_tests, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    wait (loaded);
    repeat (RESET_CYCLES + (n_tests + 1) * CYCLES_PER_TEST) @(posedge clk);
    $display("Timeout, the operations did not finish in time (%0d errors so far)", errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- all.f
design/dcache_pkg.sv
design/way_lookup.sv
design/line_store.sv
design/line_transfer.sv
design/cache_ctrl.sv
design/dcache_top.sv
testbench/mem_model.sv
testbench/tb_dcache.sv

//--- Makefile
TOP = tb_dcache

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- testbench/dcache_tests.txt
# kind addr wdata mask expect miss, all hex
# kind 0 read, 1 write, 2 read whose miss writes back a dirty line
0 00000104 00000000 0 5a5a0041 1
0 00000138 00000000 0 5a5a004e 0
1 00000108 deadbeef 5 5aad00ef 0
0 00000108 00000000 0 5aad00ef 0
1 00000284 12345678 c 123400a1 1
0 00000284 00000000 0 123400a1 0
0 00000600 00000000 0 5a5a0180 1
0 00000a00 00000000 0 5a5a0280 1
0 00000e00 00000000 0 5a5a0380 1
0 00001200 00000000 0 5a5a0480 1
1 00000608 cafef00d f cafef00d 0
0 00000a3c 00000000 0 5a5a028f 0
0 00000e20 00000000 0 5a5a0388 0
0 00001600 00000000 0 5a5a0580 1
2 00001204 00000000 0 5a5a0481 1
0 00000a00 00000000 0 5a5a0280 0
0 00000e00 00000000 0 5a5a0380 0
0 00001600 00000000 0 5a5a0580 0
0 00000608 00000000 0 cafef00d 1
0 00000600 00000000 0 5a5a0180 0
